// File: src/rv_pkg.sv
package rv_pkg;

	localparam int XLEN      = 32;
	localparam int REG_AW    = 5;
	localparam int NUM_REGS  = 32;
	// 1 KiB of words on each memory bus
	localparam int MEM_WORDS = 256;

	localparam logic [XLEN-1:0] FOUR = 32'd4;

	typedef enum logic [6:0] {
		OP_R      = 7'b0110011,
		OP_ADDI   = 7'b0010011,
		OP_LUI    = 7'b0110111,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_BRANCH = 7'b1100011,
		OP_JAL    = 7'b1101111,
		OP_JALR   = 7'b1100111
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_SLT = 3'd4
	} alu_op_e;

	// alu operand a source
	typedef enum logic [1:0] {
		A_PC_BKP = 2'd0,
		A_REG    = 2'd1,
		A_PC     = 2'd2
	} alu_a_e;

	// alu operand b source
	typedef enum logic [1:0] {
		B_REG  = 2'd0,
		B_FOUR = 2'd1,
		B_IMM  = 2'd2
	} alu_b_e;

	// register file write data source
	typedef enum logic [1:0] {
		WB_ALU = 2'd0,
		WB_PC  = 2'd1,
		WB_MEM = 2'd2,
		WB_IMM = 2'd3
	} wb_src_e;

	typedef enum logic [2:0] {
		S_FETCH_A  = 3'd0,
		S_FETCH_B  = 3'd1,
		S_DECODE   = 3'd2,
		S_EXEC     = 3'd3,
		S_MEM      = 3'd4,
		S_MEM_WAIT = 3'd5,
		S_WB       = 3'd6
	} state_e;

	// control word, valid for the cycle of the current state
	typedef struct packed {
		logic    pc_write;
		logic    pc_write_cond;
		logic    pc_src;
		logic    ir_write;
		logic    pc_bkp_write;
		logic    reg_write;
		alu_op_e alu_op;
		alu_a_e  alu_a;
		alu_b_e  alu_b;
		wb_src_e wb_src;
		logic    dmem_re;
		logic    dmem_we;
	} ctrl_t;

endpackage

// File: src/rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
	input  logic [rv_pkg::XLEN-1:0] i_a,
	input  logic [rv_pkg::XLEN-1:0] i_b,
	input  rv_pkg::alu_op_e         i_op,
	output logic [rv_pkg::XLEN-1:0] o_result,
	output logic                    o_zero
);

	always_comb begin
		case (i_op)
			rv_pkg::ALU_ADD: o_result = i_a + i_b;
			rv_pkg::ALU_SUB: o_result = i_a - i_b;
			rv_pkg::ALU_AND: o_result = i_a & i_b;
			rv_pkg::ALU_OR:  o_result = i_a | i_b;
			rv_pkg::ALU_SLT: o_result = {{(rv_pkg::XLEN-1){1'b0}}, $signed(i_a) < $signed(i_b)};
			default:         o_result = '0;
		endcase

		// beq reads the flag after a subtract, so an equality compare is enough there
		if (i_op == rv_pkg::ALU_SUB) begin
			o_zero = (i_a == i_b);
		end else begin
			o_zero = (o_result == '0);
		end

		if (!$isunknown({i_a, i_b, i_op})) begin
			zero_chk: assert (o_zero == (o_result == '0));
		end
	end

endmodule

// File: src/rv_imm_gen.sv
`timescale 1ns/1ps

module rv_imm_gen (
	input  logic [rv_pkg::XLEN-1:0] i_instr,
	output logic [rv_pkg::XLEN-1:0] o_imm
);

	always_comb begin
		case (rv_pkg::opcode_e'(i_instr[6:0]))
			// i-type
			rv_pkg::OP_LOAD, rv_pkg::OP_ADDI, rv_pkg::OP_JALR: begin
				o_imm = {{20{i_instr[31]}}, i_instr[31:20]};
			end
			rv_pkg::OP_STORE: begin
				o_imm = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
			end
			rv_pkg::OP_BRANCH: begin
				o_imm = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
			end
			rv_pkg::OP_JAL: begin
				o_imm = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};
			end
			rv_pkg::OP_LUI: begin
				o_imm = {i_instr[31:12], 12'b0};
			end
			// r-type and unknown opcodes
			default: begin
				o_imm = '0;
			end
		endcase
	end

endmodule

// File: src/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
	input  logic                      clk,
	input  logic                      i_we,
	input  logic [rv_pkg::REG_AW-1:0] i_rs1,
	input  logic [rv_pkg::REG_AW-1:0] i_rs2,
	input  logic [rv_pkg::REG_AW-1:0] i_rd,
	input  logic [rv_pkg::REG_AW-1:0] i_dbg_reg,
	input  logic [rv_pkg::XLEN-1:0]   i_wd,
	output logic [rv_pkg::XLEN-1:0]   o_rd1,
	output logic [rv_pkg::XLEN-1:0]   o_rd2,
	output logic [rv_pkg::XLEN-1:0]   o_dbg_data
);

	logic [rv_pkg::XLEN-1:0] regs [rv_pkg::NUM_REGS];

	// x0 is never stored
	always_ff @(posedge clk) begin
		if (i_we && (i_rd != '0)) begin
			regs[i_rd] <= i_wd;
		end
	end

	// x0 reads as zero on every port
	assign o_rd1      = (i_rs1 == '0) ? '0 : regs[i_rs1];
	assign o_rd2      = (i_rs2 == '0) ? '0 : regs[i_rs2];
	assign o_dbg_data = (i_dbg_reg == '0) ? '0 : regs[i_dbg_reg];

endmodule

// File: src/rv_control.sv
`timescale 1ns/1ps

module rv_control (
	input  logic                    clk,
	input  logic                    i_arst_n,
	input  logic [rv_pkg::XLEN-1:0] i_instr,
	output rv_pkg::ctrl_t           o_ctrl
);

	rv_pkg::state_e  state_q;
	rv_pkg::state_e  state_d;
	rv_pkg::ctrl_t   ctrl_d;
	rv_pkg::opcode_e opcode;
	rv_pkg::alu_op_e r_alu_op;
	logic            op_known;

	assign opcode = rv_pkg::opcode_e'(i_instr[6:0]);

	// r-type funct3/funct7 to alu operation
	always_comb begin
		case (i_instr[14:12])
			3'b000:  r_alu_op = i_instr[30] ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
			3'b111:  r_alu_op = rv_pkg::ALU_AND;
			3'b110:  r_alu_op = rv_pkg::ALU_OR;
			3'b010:  r_alu_op = rv_pkg::ALU_SLT;
			default: r_alu_op = rv_pkg::ALU_ADD;
		endcase
	end

	// only beq among the branches
	always_comb begin
		case (opcode)
			rv_pkg::OP_R, rv_pkg::OP_ADDI, rv_pkg::OP_LUI, rv_pkg::OP_LOAD,
			rv_pkg::OP_STORE, rv_pkg::OP_JAL, rv_pkg::OP_JALR: op_known = 1'b1;
			rv_pkg::OP_BRANCH: op_known = (i_instr[14:12] == 3'b000);
			default:           op_known = 1'b0;
		endcase
	end

	always_comb begin
		case (state_q)
			rv_pkg::S_FETCH_A: state_d = rv_pkg::S_FETCH_B;
			rv_pkg::S_FETCH_B: state_d = rv_pkg::S_DECODE;
			// unknown opcode goes straight back, nothing written
			rv_pkg::S_DECODE:  state_d = op_known ? rv_pkg::S_EXEC : rv_pkg::S_FETCH_A;
			rv_pkg::S_EXEC: begin
				case (opcode)
					rv_pkg::OP_R, rv_pkg::OP_ADDI:     state_d = rv_pkg::S_WB;
					rv_pkg::OP_LOAD, rv_pkg::OP_STORE: state_d = rv_pkg::S_MEM;
					default:                           state_d = rv_pkg::S_FETCH_A;
				endcase
			end
			rv_pkg::S_MEM: begin
				state_d = (opcode == rv_pkg::OP_LOAD) ? rv_pkg::S_MEM_WAIT : rv_pkg::S_FETCH_A;
			end
			rv_pkg::S_MEM_WAIT: state_d = rv_pkg::S_WB;
			default:            state_d = rv_pkg::S_FETCH_A;
		endcase
	end

	// control word for the state being entered
	always_comb begin
		ctrl_d        = '0;
		ctrl_d.alu_op = rv_pkg::ALU_ADD;
		ctrl_d.alu_a  = rv_pkg::A_REG;
		ctrl_d.alu_b  = rv_pkg::B_IMM;
		case (state_d)
			rv_pkg::S_FETCH_A: begin
				ctrl_d.pc_bkp_write = 1'b1;
				ctrl_d.alu_a        = rv_pkg::A_PC;
				ctrl_d.alu_b        = rv_pkg::B_FOUR;
			end
			rv_pkg::S_FETCH_B: begin
				ctrl_d.ir_write = 1'b1;
				ctrl_d.pc_write = 1'b1;
				ctrl_d.alu_a    = rv_pkg::A_PC;
				ctrl_d.alu_b    = rv_pkg::B_FOUR;
			end
			// branch and jal target into the alu output register
			rv_pkg::S_DECODE: begin
				ctrl_d.alu_a = rv_pkg::A_PC_BKP;
			end
			rv_pkg::S_EXEC: begin
				case (opcode)
					rv_pkg::OP_R: begin
						ctrl_d.alu_b  = rv_pkg::B_REG;
						ctrl_d.alu_op = r_alu_op;
					end
					rv_pkg::OP_LUI: begin
						ctrl_d.reg_write = 1'b1;
						ctrl_d.wb_src    = rv_pkg::WB_IMM;
					end
					rv_pkg::OP_BRANCH: begin
						ctrl_d.alu_b         = rv_pkg::B_REG;
						ctrl_d.alu_op        = rv_pkg::ALU_SUB;
						ctrl_d.pc_write_cond = 1'b1;
						ctrl_d.pc_src        = 1'b1;
					end
					rv_pkg::OP_JAL: begin
						ctrl_d.reg_write = 1'b1;
						ctrl_d.wb_src    = rv_pkg::WB_PC;
						ctrl_d.pc_write  = 1'b1;
						ctrl_d.pc_src    = 1'b1;
					end
					// target straight from the alu, link is pc+4
					rv_pkg::OP_JALR: begin
						ctrl_d.reg_write = 1'b1;
						ctrl_d.wb_src    = rv_pkg::WB_PC;
						ctrl_d.pc_write  = 1'b1;
					end
					default: begin
						ctrl_d.alu_a = rv_pkg::A_REG;
					end
				endcase
			end
			rv_pkg::S_MEM: begin
				ctrl_d.dmem_re = (opcode == rv_pkg::OP_LOAD);
				ctrl_d.dmem_we = (opcode == rv_pkg::OP_STORE);
			end
			rv_pkg::S_WB: begin
				ctrl_d.reg_write = 1'b1;
				ctrl_d.wb_src    = (opcode == rv_pkg::OP_LOAD) ? rv_pkg::WB_MEM : rv_pkg::WB_ALU;
			end
			default: begin
				ctrl_d.alu_a = rv_pkg::A_REG;
			end
		endcase
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state_q <= rv_pkg::S_FETCH_A;
			o_ctrl  <= '0;
		end else begin
			state_q <= state_d;
			o_ctrl  <= ctrl_d;
		end
	end

	// a store never retires a register result
	we_excl_chk: assert property (@(posedge clk) disable iff (!i_arst_n)
		!(o_ctrl.dmem_we && o_ctrl.reg_write));

endmodule

// File: src/rv_datapath.sv
`timescale 1ns/1ps

module rv_datapath (
	input  logic                      clk,
	input  logic                      i_arst_n,
	input  rv_pkg::ctrl_t             i_ctrl,
	input  logic [rv_pkg::XLEN-1:0]   i_imem_rdata,
	input  logic [rv_pkg::XLEN-1:0]   i_dmem_rdata,
	input  logic [rv_pkg::REG_AW-1:0] i_dbg_reg,
	output logic [rv_pkg::XLEN-1:0]   o_instr,
	output logic [rv_pkg::XLEN-1:0]   o_imem_addr,
	output logic [rv_pkg::XLEN-1:0]   o_dmem_addr,
	output logic [rv_pkg::XLEN-1:0]   o_dmem_wdata,
	output logic                      o_dmem_we,
	output logic                      o_dmem_re,
	output logic [rv_pkg::XLEN-1:0]   o_dbg_data
);

	logic [rv_pkg::XLEN-1:0] pc_q;
	logic [rv_pkg::XLEN-1:0] pc_bkp_q;
	logic [rv_pkg::XLEN-1:0] ir_q;
	logic [rv_pkg::XLEN-1:0] a_q;
	logic [rv_pkg::XLEN-1:0] b_q;
	logic [rv_pkg::XLEN-1:0] alu_out_q;
	logic [rv_pkg::XLEN-1:0] mdr_q;
	logic [rv_pkg::XLEN-1:0] rd1;
	logic [rv_pkg::XLEN-1:0] rd2;
	logic [rv_pkg::XLEN-1:0] imm;
	logic [rv_pkg::XLEN-1:0] alu_a;
	logic [rv_pkg::XLEN-1:0] alu_b;
	logic [rv_pkg::XLEN-1:0] alu_result;
	logic [rv_pkg::XLEN-1:0] wb_data;
	logic [rv_pkg::XLEN-1:0] pc_next;
	logic                    alu_zero;
	logic                    pc_en;

	rv_regfile u_rv_regfile (
		.clk        (clk),
		.i_we       (i_ctrl.reg_write),
		.i_rs1      (ir_q[19:15]),
		.i_rs2      (ir_q[24:20]),
		.i_rd       (ir_q[11:7]),
		.i_dbg_reg  (i_dbg_reg),
		.i_wd       (wb_data),
		.o_rd1      (rd1),
		.o_rd2      (rd2),
		.o_dbg_data (o_dbg_data)
	);

	rv_imm_gen u_rv_imm_gen (
		.i_instr (ir_q),
		.o_imm   (imm)
	);

	always_comb begin
		case (i_ctrl.alu_a)
			rv_pkg::A_PC_BKP: alu_a = pc_bkp_q;
			rv_pkg::A_REG:    alu_a = a_q;
			rv_pkg::A_PC:     alu_a = pc_q;
			default:          alu_a = '0;
		endcase
	end

	always_comb begin
		case (i_ctrl.alu_b)
			rv_pkg::B_REG:  alu_b = b_q;
			rv_pkg::B_FOUR: alu_b = rv_pkg::FOUR;
			rv_pkg::B_IMM:  alu_b = imm;
			default:        alu_b = '0;
		endcase
	end

	rv_alu u_rv_alu (
		.i_a      (alu_a),
		.i_b      (alu_b),
		.i_op     (i_ctrl.alu_op),
		.o_result (alu_result),
		.o_zero   (alu_zero)
	);

	always_comb begin
		case (i_ctrl.wb_src)
			rv_pkg::WB_ALU: wb_data = alu_out_q;
			rv_pkg::WB_PC:  wb_data = pc_q;
			rv_pkg::WB_MEM: wb_data = mdr_q;
			default:        wb_data = imm;
		endcase
	end

	// saved target from decode, or the live alu result with bit 0 cleared for jalr
	assign pc_next = i_ctrl.pc_src ? alu_out_q : {alu_result[rv_pkg::XLEN-1:1], 1'b0};
	assign pc_en   = i_ctrl.pc_write | (i_ctrl.pc_write_cond & alu_zero);

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			pc_q     <= '0;
			pc_bkp_q <= '0;
			ir_q     <= '0;
		end else begin
			if (pc_en) begin
				pc_q <= pc_next;
			end
			if (i_ctrl.pc_bkp_write) begin
				pc_bkp_q <= pc_q;
			end
			if (i_ctrl.ir_write) begin
				ir_q <= i_imem_rdata;
			end
		end
	end

	// these just follow their sources every cycle
	always_ff @(posedge clk) begin
		a_q       <= rd1;
		b_q       <= rd2;
		alu_out_q <= alu_result;
		mdr_q     <= i_dmem_rdata;
	end

	assign o_instr      = ir_q;
	assign o_imem_addr  = pc_q;
	assign o_dmem_addr  = alu_out_q;
	assign o_dmem_wdata = b_q;
	assign o_dmem_we    = i_ctrl.dmem_we;
	assign o_dmem_re    = i_ctrl.dmem_re;

	pc_align_chk: assert property (@(posedge clk) disable iff (!i_arst_n)
		pc_q[1:0] == 2'b00);

endmodule

// File: src/rv_core.sv
`timescale 1ns/1ps

module rv_core (
	input  logic                      clk,
	input  logic                      i_arst_n,
	// instruction bus
	output logic [rv_pkg::XLEN-1:0]   o_imem_addr,
	input  logic [rv_pkg::XLEN-1:0]   i_imem_rdata,
	// data bus
	output logic [rv_pkg::XLEN-1:0]   o_dmem_addr,
	output logic [rv_pkg::XLEN-1:0]   o_dmem_wdata,
	output logic                      o_dmem_we,
	output logic                      o_dmem_re,
	input  logic [rv_pkg::XLEN-1:0]   i_dmem_rdata,
	// register display
	input  logic [rv_pkg::REG_AW-1:0] i_dbg_reg,
	output logic [rv_pkg::XLEN-1:0]   o_dbg_data
);

	rv_pkg::ctrl_t           ctrl;
	logic [rv_pkg::XLEN-1:0] instr;

	rv_control u_rv_control (
		.clk      (clk),
		.i_arst_n (i_arst_n),
		.i_instr  (instr),
		.o_ctrl   (ctrl)
	);

	rv_datapath u_rv_datapath (
		.clk          (clk),
		.i_arst_n     (i_arst_n),
		.i_ctrl       (ctrl),
		.i_imem_rdata (i_imem_rdata),
		.i_dmem_rdata (i_dmem_rdata),
		.i_dbg_reg    (i_dbg_reg),
		.o_instr      (instr),
		.o_imem_addr  (o_imem_addr),
		.o_dmem_addr  (o_dmem_addr),
		.o_dmem_wdata (o_dmem_wdata),
		.o_dmem_we    (o_dmem_we),
		.o_dmem_re    (o_dmem_re),
		.o_dbg_data   (o_dbg_data)
	);

endmodule

// File: include/rv_ref_model.svh
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// one write as it appears on the data bus
typedef struct packed {
	logic [rv_pkg::XLEN-1:0] addr;
	logic [rv_pkg::XLEN-1:0] data;
} ref_store_t;

// instruction-level run, stops at a jal to itself or after max_steps
function automatic void rv_ref_run(
	input  logic [rv_pkg::XLEN-1:0] prog [rv_pkg::MEM_WORDS],
	input  logic [rv_pkg::XLEN-1:0] dmem_init [rv_pkg::MEM_WORDS],
	input  int unsigned             max_steps,
	output logic [rv_pkg::XLEN-1:0] regs [rv_pkg::NUM_REGS],
	output ref_store_t              stores [$]
);
	logic [rv_pkg::XLEN-1:0] dmem [rv_pkg::MEM_WORDS];
	logic [rv_pkg::XLEN-1:0] pc;
	logic [rv_pkg::XLEN-1:0] instr;
	logic [rv_pkg::XLEN-1:0] src1;
	logic [rv_pkg::XLEN-1:0] src2;
	logic [rv_pkg::XLEN-1:0] imm_i;
	logic [rv_pkg::XLEN-1:0] imm_s;
	logic [rv_pkg::XLEN-1:0] imm_b;
	logic [rv_pkg::XLEN-1:0] imm_j;
	logic [rv_pkg::XLEN-1:0] addr;
	logic [rv_pkg::XLEN-1:0] result;
	logic [rv_pkg::XLEN-1:0] pc_next;
	logic                    wr;
	logic                    halt;

	dmem = dmem_init;
	stores = {};
	foreach (regs[i]) begin
		regs[i] = '0;
	end
	pc   = '0;
	halt = 1'b0;
	for (int unsigned step = 0; (step < max_steps) && !halt; step++) begin
		instr   = prog[(pc >> 2) % rv_pkg::MEM_WORDS];
		src1    = regs[instr[19:15]];
		src2    = regs[instr[24:20]];
		imm_i   = {{20{instr[31]}}, instr[31:20]};
		imm_s   = {{20{instr[31]}}, instr[31:25], instr[11:7]};
		imm_b   = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
		imm_j   = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
		result  = '0;
		wr      = 1'b0;
		pc_next = pc + rv_pkg::FOUR;
		case (instr[6:0])
			rv_pkg::OP_R: begin
				wr = 1'b1;
				case (instr[14:12])
					3'b000:  result = instr[30] ? src1 - src2 : src1 + src2;
					3'b111:  result = src1 & src2;
					3'b110:  result = src1 | src2;
					3'b010:  result = ($signed(src1) < $signed(src2)) ? 32'd1 : 32'd0;
					default: result = src1 + src2;
				endcase
			end
			rv_pkg::OP_ADDI: begin
				wr     = 1'b1;
				result = src1 + imm_i;
			end
			rv_pkg::OP_LUI: begin
				wr     = 1'b1;
				result = {instr[31:12], 12'b0};
			end
			rv_pkg::OP_LOAD: begin
				wr     = 1'b1;
				result = dmem[((src1 + imm_i) >> 2) % rv_pkg::MEM_WORDS];
			end
			rv_pkg::OP_STORE: begin
				addr = src1 + imm_s;
				dmem[(addr >> 2) % rv_pkg::MEM_WORDS] = src2;
				stores.push_back('{addr: addr, data: src2});
			end
			// beq only, other funct3 values do nothing
			rv_pkg::OP_BRANCH: begin
				if ((instr[14:12] == 3'b000) && (src1 == src2)) begin
					pc_next = pc + imm_b;
				end
			end
			rv_pkg::OP_JAL: begin
				wr      = 1'b1;
				result  = pc + rv_pkg::FOUR;
				pc_next = pc + imm_j;
				halt    = (imm_j == '0);
			end
			rv_pkg::OP_JALR: begin
				wr      = 1'b1;
				result  = pc + rv_pkg::FOUR;
				pc_next = (src1 + imm_i) & ~32'd1;
			end
			default: begin
				wr = 1'b0;
			end
		endcase
		if (wr && (instr[11:7] != 5'd0)) begin
			regs[instr[11:7]] = result;
		end
		pc = pc_next;
	end
endfunction

`endif

// File: sim/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

	`include "rv_ref_model.svh"

	localparam int          CLK_PERIOD    = 20;
	localparam int          RST_CYCLES    = 10;
	localparam int          HALT_HOLD     = 16;
	localparam int          RAND_OPS      = 40;
	localparam int          RAND_PROGRAMS = 3;
	localparam int          NUM_PROGRAMS  = 4 + RAND_PROGRAMS;
	localparam int unsigned MAX_INSTR     = 128;
	localparam longint      TIMEOUT_NS    = NUM_PROGRAMS * MAX_INSTR * 6 * 2 * CLK_PERIOD;
	localparam logic [31:0] SEED          = 32'h0c1bcfd3;

	logic                           clk;
	logic                           arst_n;
	logic [rv_pkg::XLEN-1:0]        imem_rdata = '0;
	logic [rv_pkg::XLEN-1:0]        dmem_rdata = '0;
	logic [rv_pkg::REG_AW-1:0]      dbg_reg;
	logic [rv_pkg::XLEN-1:0]        o_imem_addr;
	logic [rv_pkg::XLEN-1:0]        o_dmem_addr;
	logic [rv_pkg::XLEN-1:0]        o_dmem_wdata;
	logic                           o_dmem_we;
	logic                           o_dmem_re;
	logic [rv_pkg::XLEN-1:0]        o_dbg_data;

	logic [rv_pkg::XLEN-1:0]        imem [rv_pkg::MEM_WORDS];
	logic [rv_pkg::XLEN-1:0]        dmem [rv_pkg::MEM_WORDS];
	logic [rv_pkg::XLEN-1:0]        dmem_init [rv_pkg::MEM_WORDS];
	logic [rv_pkg::XLEN-1:0]        exp_regs [rv_pkg::NUM_REGS];
	ref_store_t                     exp_stores [$];
	logic [7:0]                     prog_len;
	logic [rv_pkg::XLEN-1:0]        halt_addr;
	int                             store_idx;
	logic                           re_last;

	rv_core u_rv_core (
		.clk          (clk),
		.i_arst_n     (arst_n),
		.o_imem_addr  (o_imem_addr),
		.i_imem_rdata (imem_rdata),
		.o_dmem_addr  (o_dmem_addr),
		.o_dmem_wdata (o_dmem_wdata),
		.o_dmem_we    (o_dmem_we),
		.o_dmem_re    (o_dmem_re),
		.i_dmem_rdata (dmem_rdata),
		.i_dbg_reg    (dbg_reg),
		.o_dbg_data   (o_dbg_data)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	// instruction encoders
	function automatic logic [31:0] r_type(int rd, int rs1, int rs2, logic [2:0] f3, logic sub);
		return {1'b0, sub, 5'd0, rs2[4:0], rs1[4:0], f3, rd[4:0], rv_pkg::OP_R};
	endfunction
	function automatic logic [31:0] addi(int rd, int rs1, int imm);
		return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], rv_pkg::OP_ADDI};
	endfunction
	function automatic logic [31:0] lui(int rd, int imm);
		return {imm[19:0], rd[4:0], rv_pkg::OP_LUI};
	endfunction
	function automatic logic [31:0] lw(int rd, int rs1, int imm);
		return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], rv_pkg::OP_LOAD};
	endfunction
	function automatic logic [31:0] sw(int rs2, int rs1, int imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], rv_pkg::OP_STORE};
	endfunction
	function automatic logic [31:0] beq(int rs1, int rs2, int off);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], 3'b000, off[4:1], off[11],
			rv_pkg::OP_BRANCH};
	endfunction
	function automatic logic [31:0] jal(int rd, int off);
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], rv_pkg::OP_JAL};
	endfunction
	function automatic logic [31:0] jalr(int rd, int rs1, int imm);
		return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], rv_pkg::OP_JALR};
	endfunction

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Testbench failed");
		$fatal(1, "run stopped at the first error");
	endtask

	// both memories answer on the falling edge and hold the data into the next cycle
	always @(negedge clk) begin
		imem_rdata <= imem[o_imem_addr[9:2]];
		if (!arst_n) begin
			foreach (dmem[i]) begin
				dmem[i] <= dmem_init[i];
			end
		end else begin
			if (o_dmem_re) begin
				dmem_rdata <= dmem[o_dmem_addr[9:2]];
			end
			if (o_dmem_we) begin
				dmem[o_dmem_addr[9:2]] <= o_dmem_wdata;
			end
		end
	end

	// write strobes in order against the reference store list
	// read strobes last one cycle and never meet a write
	always @(negedge clk) begin
		if (!arst_n) begin
			store_idx <= 0;
			re_last   <= 1'b0;
		end else begin
			re_last <= o_dmem_re;
			assert (!(o_dmem_re && (o_dmem_we || re_last)))
			else fail_run($sformatf("Error at %0t: read strobe at %h is longer than a cycle %s",
				$time, o_dmem_addr, "or overlaps a write"));
			if (o_dmem_we) begin
				assert (store_idx < exp_stores.size())
				else fail_run($sformatf("Error at %0t: extra store to %h", $time, o_dmem_addr));
				assert ((o_dmem_addr === exp_stores[store_idx].addr) &&
					(o_dmem_wdata === exp_stores[store_idx].data))
				else fail_run($sformatf("Error at %0t: store %0d is %h <- %h, expected %h <- %h",
					$time, store_idx, o_dmem_addr, o_dmem_wdata,
					exp_stores[store_idx].addr, exp_stores[store_idx].data));
				store_idx <= store_idx + 1;
			end
		end
	end

	task automatic emit(input logic [31:0] word);
		imem[prog_len] = word;
		prog_len++;
	endtask

	// holds the core in reset while the new program is loaded
	task automatic start_program();
		@(negedge clk);
		arst_n = 1'b0;
		foreach (imem[i]) begin
			imem[i] = '0;
		end
		prog_len = '0;
		// register file keeps old values across reset, so clear x1..x31 first
		for (int r = 1; r < rv_pkg::NUM_REGS; r++) begin
			emit(addi(r, 0, 0));
		end
	endtask

	task automatic run_program(input string name);
		int hold;
		emit(jal(0, 0));
		rv_ref_run(imem, dmem_init, MAX_INSTR, exp_regs, exp_stores);
		halt_addr = {22'd0, prog_len - 8'd1, 2'b00};
		repeat (RST_CYCLES) @(negedge clk);
		arst_n = 1'b1;
		// pc steps to halt+4 in fetch and back in execute
		hold = 0;
		while (hold < HALT_HOLD) begin
			@(negedge clk);
			if ((o_imem_addr == halt_addr) || (o_imem_addr == halt_addr + rv_pkg::FOUR)) begin
				hold++;
			end else begin
				hold = 0;
			end
		end
		assert (store_idx == exp_stores.size())
		else fail_run($sformatf("Error at %0t: %s made %0d stores, expected %0d",
			$time, name, store_idx, exp_stores.size()));
		for (int r = 0; r < rv_pkg::NUM_REGS; r++) begin
			@(negedge clk);
			dbg_reg = r[4:0];
			#(CLK_PERIOD / 4);
			assert (o_dbg_data === exp_regs[r[4:0]])
			else fail_run($sformatf("Error at %0t: %s x%0d is %h, expected %h",
				$time, name, r, o_dbg_data, exp_regs[r[4:0]]));
		end
		$display("%s program checked, %0d stores", name, store_idx);
	endtask

	task automatic build_random_program();
		logic [31:0] rnd;
		int unsigned sel;
		int          rd;
		int          rs1;
		int          rs2;
		start_program();
		for (int n = 0; n < RAND_OPS; n++) begin
			rnd = $urandom();
			sel = $urandom_range(6, 0);
			rd  = int'(rnd[4:0]);
			rs1 = int'(rnd[9:5]);
			rs2 = int'(rnd[14:10]);
			case (sel)
				0:       emit(r_type(rd, rs1, rs2, 3'b000, 1'b0));
				1:       emit(r_type(rd, rs1, rs2, 3'b000, 1'b1));
				2:       emit(r_type(rd, rs1, rs2, 3'b111, 1'b0));
				3:       emit(r_type(rd, rs1, rs2, 3'b110, 1'b0));
				4:       emit(r_type(rd, rs1, rs2, 3'b010, 1'b0));
				5:       emit(addi(rd, rs1, int'(rnd >> 20)));
				default: emit(lui(rd, int'(rnd >> 12)));
			endcase
		end
		for (int r = 0; r < rv_pkg::NUM_REGS; r++) begin
			emit(sw(r, 0, 512 + 4 * r));
		end
	endtask

	initial begin
		arst_n   = 1'b0;
		dbg_reg  = '0;
		prog_len = '0;
		void'($urandom(SEED));
		foreach (dmem_init[i]) begin
			dmem_init[i] = (i * 32'h9e3779b1) ^ 32'hc3a50f1e;
		end

		// alu results and slt with negative operands
		start_program();
		emit(addi(1, 0, 100));
		emit(addi(2, 0, -7));
		emit(lui(3, 'hfffff));
		emit(r_type(4, 1, 2, 3'b000, 1'b0));
		emit(r_type(5, 2, 1, 3'b000, 1'b1));
		emit(r_type(6, 1, 2, 3'b111, 1'b0));
		emit(r_type(7, 1, 2, 3'b110, 1'b0));
		emit(r_type(8, 2, 1, 3'b010, 1'b0));
		emit(r_type(9, 1, 2, 3'b010, 1'b0));
		emit(r_type(10, 5, 2, 3'b010, 1'b0));
		emit(r_type(11, 3, 0, 3'b010, 1'b0));
		emit(addi(12, 3, -1));
		emit(lui(13, 'h12345));
		emit(addi(13, 13, 'h678));
		emit(r_type(14, 0, 3, 3'b000, 1'b1));
		run_program("alu");

		// writes aimed at x0
		start_program();
		emit(addi(1, 0, 9));
		emit(addi(0, 0, 55));
		emit(lui(0, 'habcde));
		emit(r_type(0, 1, 1, 3'b000, 1'b0));
		emit(lw(0, 0, 8));
		emit(jal(0, 4));
		emit(r_type(2, 0, 1, 3'b000, 1'b0));
		emit(sw(0, 0, 32));
		run_program("x0");

		// store and load round trips around a base in x1
		start_program();
		emit(addi(1, 0, 256));
		emit(addi(2, 0, -300));
		emit(lui(3, 'hdead0));
		emit(addi(3, 3, 'h2ef));
		emit(sw(2, 1, 0));
		emit(sw(3, 1, 8));
		emit(sw(1, 1, -4));
		emit(sw(3, 1, -16));
		emit(lw(4, 1, 0));
		emit(lw(5, 1, 8));
		emit(lw(6, 1, -4));
		emit(lw(7, 1, -16));
		emit(lw(8, 1, 20));
		emit(r_type(9, 4, 5, 3'b000, 1'b0));
		emit(sw(9, 1, -256));
		emit(lw(10, 0, 0));
		run_program("load/store");

		// skipped instructions write x5, x7 and x9, which must stay zero
		start_program();
		emit(addi(1, 0, 5));
		emit(addi(2, 0, 5));
		emit(addi(3, 0, 6));
		emit(beq(1, 3, 8));
		emit(addi(4, 0, 1));
		emit(beq(1, 2, 8));
		emit(addi(5, 0, 99));
		emit(jal(6, 8));
		emit(addi(7, 0, 77));
		// odd offset drops bit 0 of the target
		emit(jalr(8, 6, 13));
		emit(addi(9, 0, 55));
		emit(addi(10, 0, 3));
		emit(jal(0, 12));
		emit(addi(14, 0, 42));
		emit(jal(0, 8));
		emit(beq(0, 0, -8));
		emit(addi(13, 0, -1));
		emit(beq(13, 1, -4));
		run_program("branch");

		for (int p = 0; p < RAND_PROGRAMS; p++) begin
			build_random_program();
			run_program($sformatf("random %0d", p));
		end

		$display("Testbench passed");
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		fail_run($sformatf("Timeout: programs still running after %0d ns", TIMEOUT_NS));
	end

endmodule

// File: tb.f
+incdir+include
src/rv_pkg.sv
src/rv_alu.sv
src/rv_imm_gen.sv
src/rv_regfile.sv
src/rv_control.sv
src/rv_datapath.sv
src/rv_core.sv
sim/tb_rv_core.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_rv_core
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
